// ==== logic/pixel_feeder_cfg.svh ====
// ============================
// pixel feeder configuration
// frame geometry, burst length, FIFO depths
// ============================
`ifndef PIXEL_FEEDER_CFG_SVH
`define PIXEL_FEEDER_CFG_SVH

// pixels per row, rows per frame
`define FRAME_WIDTH 32
`define FRAME_HEIGHT 4

// pixels packed in one 128-bit memory line
`define LINE_PIXELS 4

// requests issued per refill burst
`define REQ_BURST 8

// buffer sizes, both powers of two
`define LINE_FIFO_DEPTH 32
`define PIXEL_FIFO_DEPTH 16

`endif

// ==== logic/mem_pkg.sv ====
// ============================
// memory side types
// line data, byte address, line counts
// ============================
`default_nettype none

package mem_pkg;

    // one read beat from the memory controller
    typedef logic [127:0] mem_line_t;

    // byte address on the request port
    typedef logic [30:0] mem_addr_t;

    // holds 0 .. LINE_FIFO_DEPTH with room to spare
    typedef logic [5:0] line_count_t;

endpackage

`default_nettype wire

// ==== logic/video_pkg.sv ====
// ============================
// video side types
// pixels, register map, frame counter
// ============================
`default_nettype none

package video_pkg;

    // one unpacked word, rgb in bits 23:0
    typedef logic [31:0] pixel_word_t;

    // pixel as sent to the display
    typedef logic [23:0] pixel_t;

    // completed frames since reset
    typedef logic [15:0] frame_count_t;

    // register byte offset
    typedef logic [3:0] reg_addr_t;

    localparam reg_addr_t REG_BASE   = 4'h0;
    localparam reg_addr_t REG_CTRL   = 4'h4;
    localparam reg_addr_t REG_STATUS = 4'h8;
    localparam reg_addr_t REG_FCOUNT = 4'hC;

endpackage

`default_nettype wire

// ==== logic/sync_fifo.sv ====
// ============================
// synchronous FIFO
// show-ahead, single clock, any payload type
// ============================
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 16
) (
    input  wire logic     cpu_clk_g,
    input  wire logic     rst,
    input  wire logic     wr_en,
    input  wire payload_t din,
    input  wire logic     rd_en,
    output payload_t      dout,
    output logic          full,
    output logic          empty,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int AW = $clog2(DEPTH);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic            do_wr;
    logic            do_rd;

    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // head entry visible without a read strobe
    assign dout  = mem[rd_ptr];
    assign full  = (count == DEPTH[$clog2(DEPTH+1)-1:0]);
    assign empty = (count == '0);

    always_ff @(posedge cpu_clk_g) begin
        if (do_wr)
            mem[wr_ptr] <= din;
    end

    // pointers wrap naturally, DEPTH is a power of two
    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    assert property (@(posedge cpu_clk_g) disable iff (rst) wr_en |-> !full);
    assert property (@(posedge cpu_clk_g) disable iff (rst) rd_en |-> !empty);

endmodule

`default_nettype wire

// ==== logic/feeder_regs.sv ====
// ============================
// feeder register block
// AXI4-Lite slave for base, control, status
// and frame count, drives frame interrupt
// ============================
`timescale 1ns/1ps
`default_nettype none

module feeder_regs
    import mem_pkg::*;
    import video_pkg::*;
(
    input  wire logic      cpu_clk_g,
    input  wire logic      rst,
    input  wire reg_addr_t awaddr,
    input  wire logic      awvalid,
    output logic           awready,
    input  wire logic [31:0] wdata,
    input  wire logic [3:0]  wstrb,
    input  wire logic      wvalid,
    output logic           wready,
    output logic [1:0]     bresp,
    output logic           bvalid,
    input  wire logic      bready,
    input  wire reg_addr_t araddr,
    input  wire logic      arvalid,
    output logic           arready,
    output logic [31:0]    rdata,
    output logic [1:0]     rresp,
    output logic           rvalid,
    input  wire logic      rready,
    input  wire logic      frame_wrap,
    output mem_addr_t      frame_base,
    output logic           scan_enable,
    output logic           irq
);

    logic [31:0]  base_reg;
    logic         irq_en;
    logic         frame_done;
    frame_count_t frame_count;
    logic         wr_accept;
    logic         rd_accept;
    logic [31:0]  rd_mux;

    // address and data taken together, one at a time
    assign wr_accept = awvalid & wvalid & ~bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    // a read waits for the previous response to drain
    assign rd_accept = arvalid & ~rvalid;
    assign arready   = rd_accept;

    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // pending base, the walker picks it up at frame wrap
    assign frame_base = base_reg[$bits(mem_addr_t)-1:0];
    assign irq        = frame_done & irq_en;

    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            base_reg    <= '0;
            scan_enable <= 1'b0;
            irq_en      <= 1'b0;
            frame_done  <= 1'b0;
            frame_count <= '0;
            bvalid      <= 1'b0;
            rvalid      <= 1'b0;
        end else begin
            if (wr_accept && awaddr == REG_BASE) begin
                for (int i = 0; i < 4; i++) begin
                    if (wstrb[i])
                        base_reg[8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            if (wr_accept && awaddr == REG_CTRL && wstrb[0]) begin
                scan_enable <= wdata[0];
                irq_en      <= wdata[1];
            end
            // sticky, a new frame wins over a clear in the same cycle
            if (frame_wrap)
                frame_done <= 1'b1;
            else if (wr_accept && awaddr == REG_STATUS && wstrb[0] && wdata[0])
                frame_done <= 1'b0;
            if (frame_wrap)
                frame_count <= frame_count + 1'b1;
            // write response
            if (wr_accept)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            // read response
            if (rd_accept)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_comb begin
        case (araddr)
            REG_BASE:   rd_mux = base_reg;
            REG_CTRL:   rd_mux = {30'b0, irq_en, scan_enable};
            REG_STATUS: rd_mux = {31'b0, frame_done};
            REG_FCOUNT: rd_mux = {16'b0, frame_count};
            default:    rd_mux = '0;
        endcase
    end

    // read data captured at accept, valid one cycle later
    always_ff @(posedge cpu_clk_g) begin
        if (rd_accept)
            rdata <= rd_mux;
    end

    // every write response traces back to an accepted write
    assert property (@(posedge cpu_clk_g) disable iff (rst)
        $rose(bvalid) |-> $past(wr_accept));

endmodule

`default_nettype wire

// ==== logic/line_request_gen.sv ====
// ============================
// line request generator
// raster walk of the frame, issues line
// requests in bursts when buffer credit allows
// ============================
`timescale 1ns/1ps
`default_nettype none
`include "pixel_feeder_cfg.svh"

module line_request_gen
    import mem_pkg::*;
(
    input  wire logic        cpu_clk_g,
    input  wire logic        rst,
    input  wire logic        scan_enable,
    input  wire mem_addr_t   frame_base,
    input  wire logic        req_ready,
    input  wire logic        rd_valid,
    input  wire line_count_t lines_buffered,
    input  wire logic        line_pop,
    output logic             req_valid,
    output mem_addr_t        req_addr,
    output logic             frame_wrap
);

    localparam int X_W  = $clog2(`FRAME_WIDTH);
    localparam int Y_W  = $clog2(`FRAME_HEIGHT);
    localparam int CW   = $bits(line_count_t) + 1;
    localparam int BW   = $clog2(`REQ_BURST + 1);

    typedef enum logic {IDLE, ISSUE} state_t;

    state_t           state;
    logic [X_W-1:0]   x;
    logic [Y_W-1:0]   y;
    mem_addr_t        active_base;
    mem_addr_t        pix_index;
    line_count_t      outstanding;
    logic [BW-1:0]    burst_left;
    logic [CW-1:0]    credit_sum;
    logic             credit_ok;
    logic             req_fire;
    logic             last_x;
    logic             last_y;

    assign req_valid = (state == ISSUE);
    assign req_fire  = req_valid & req_ready;

    assign last_x = (x == X_W'(`FRAME_WIDTH - `LINE_PIXELS));
    assign last_y = (y == Y_W'(`FRAME_HEIGHT - 1));

    // pulse on acceptance of the final line of the frame
    assign frame_wrap = req_fire & last_x & last_y;

    // byte address, four bytes per pixel word
    assign pix_index = mem_addr_t'(y) * mem_addr_t'(`FRAME_WIDTH) + mem_addr_t'(x);
    assign req_addr  = active_base + (pix_index << 2);

    // buffered + in flight + next burst must fit the line FIFO
    // a pop this cycle already frees one slot
    assign credit_sum = CW'(lines_buffered) - CW'(line_pop) + CW'(outstanding)
                      + CW'(`REQ_BURST);
    assign credit_ok  = (credit_sum <= CW'(`LINE_FIFO_DEPTH));

    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            state       <= IDLE;
            burst_left  <= '0;
            x           <= '0;
            y           <= '0;
            active_base <= '0;
            outstanding <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (scan_enable && credit_ok) begin
                        state      <= ISSUE;
                        burst_left <= BW'(`REQ_BURST);
                    end
                end
                ISSUE: begin
                    if (req_fire) begin
                        burst_left <= burst_left - 1'b1;
                        if (burst_left == BW'(1))
                            state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase

            // raster walk
            if (req_fire) begin
                if (last_x) begin
                    x <= '0;
                    y <= last_y ? '0 : y + 1'b1;
                end else begin
                    x <= x + X_W'(`LINE_PIXELS);
                end
            end

            // new base only at frame boundary, or while stopped
            if (frame_wrap || (!scan_enable && state == IDLE))
                active_base <= frame_base;

            // lines requested but not yet returned
            case ({req_fire, rd_valid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // the line FIFO can always absorb what is in flight
    assert property (@(posedge cpu_clk_g) disable iff (rst)
        (CW'(outstanding) + CW'(lines_buffered)) <= CW'(`LINE_FIFO_DEPTH));

    // a request holds its address until taken
    assert property (@(posedge cpu_clk_g) disable iff (rst)
        (req_valid && !req_ready) |=> (req_valid && $stable(req_addr)));

endmodule

`default_nettype wire

// ==== logic/line_unpacker.sv ====
// ============================
// line unpacker
// splits each memory line into four
// pixel words, lowest address first
// ============================
`timescale 1ns/1ps
`default_nettype none

module line_unpacker
    import mem_pkg::*;
    import video_pkg::*;
(
    input  wire logic      cpu_clk_g,
    input  wire logic      rst,
    input  wire mem_line_t line,
    input  wire logic      line_empty,
    input  wire logic      pix_full,
    output logic           line_pop,
    output logic           pix_wr_en,
    output pixel_word_t    pix_word
);

    // word position within the head line
    logic [1:0] lane;

    // one word per cycle while there is a line and room for it
    assign pix_wr_en = ~line_empty & ~pix_full;

    // word k of the line sits in bits 32k+31:32k
    assign pix_word = pixel_word_t'(line[lane*32 +: 32]);

    // release the line with its last word
    assign line_pop = pix_wr_en & (lane == 2'd3);

    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            lane <= 2'd0;
        end else if (pix_wr_en) begin
            // wraps to lane 0 on pop
            lane <= lane + 2'd1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pixel_feeder.sv ====
// ============================
// pixel feeder top
// registers, request walker, line and
// pixel FIFOs, and unpacker
// ============================
`timescale 1ns/1ps
`default_nettype none
`include "pixel_feeder_cfg.svh"

module pixel_feeder
    import mem_pkg::*;
    import video_pkg::*;
(
    input  wire logic        cpu_clk_g,
    input  wire logic        rst,
    input  wire reg_addr_t   awaddr,
    input  wire logic        awvalid,
    output logic             awready,
    input  wire logic [31:0] wdata,
    input  wire logic [3:0]  wstrb,
    input  wire logic        wvalid,
    output logic             wready,
    output logic [1:0]       bresp,
    output logic             bvalid,
    input  wire logic        bready,
    input  wire reg_addr_t   araddr,
    input  wire logic        arvalid,
    output logic             arready,
    output logic [31:0]      rdata,
    output logic [1:0]       rresp,
    output logic             rvalid,
    input  wire logic        rready,
    output logic             req_valid,
    input  wire logic        req_ready,
    output mem_addr_t        req_addr,
    input  wire logic        rd_valid,
    input  wire mem_line_t   rd_data,
    output pixel_t           video,
    output logic             video_valid,
    input  wire logic        video_ready,
    output logic             irq
);

    mem_addr_t   frame_base;
    logic        scan_enable;
    logic        frame_wrap;
    mem_line_t   line_head;
    logic        line_empty;
    logic        line_pop;
    line_count_t lines_buffered;
    logic        pix_wr_en;
    pixel_word_t pix_word;
    pixel_word_t pix_head;
    logic        pix_full;
    logic        pix_empty;

    assign video_valid = ~pix_empty;
    assign video       = pixel_t'(pix_head[23:0]);

    feeder_regs regs_i (
        .cpu_clk_g (cpu_clk_g),   .rst (rst),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .frame_wrap (frame_wrap), .frame_base (frame_base),
        .scan_enable (scan_enable), .irq (irq)
    );

    line_request_gen req_gen_i (
        .cpu_clk_g (cpu_clk_g), .rst (rst),
        .scan_enable (scan_enable), .frame_base (frame_base),
        .req_ready (req_ready), .rd_valid (rd_valid),
        .lines_buffered (lines_buffered), .line_pop (line_pop),
        .req_valid (req_valid), .req_addr (req_addr), .frame_wrap (frame_wrap)
    );

    // read data lands here unthrottled, credit keeps it from overflowing
    sync_fifo #(.payload_t (mem_line_t), .DEPTH (`LINE_FIFO_DEPTH)) line_fifo_i (
        .cpu_clk_g (cpu_clk_g), .rst (rst),
        .wr_en (rd_valid), .din (rd_data), .rd_en (line_pop),
        .dout (line_head), .full (), .empty (line_empty), .count (lines_buffered)
    );

    line_unpacker unpacker_i (
        .cpu_clk_g (cpu_clk_g), .rst (rst),
        .line (line_head), .line_empty (line_empty), .pix_full (pix_full),
        .line_pop (line_pop), .pix_wr_en (pix_wr_en), .pix_word (pix_word)
    );

    sync_fifo #(.payload_t (pixel_word_t), .DEPTH (`PIXEL_FIFO_DEPTH)) pixel_fifo_i (
        .cpu_clk_g (cpu_clk_g), .rst (rst),
        .wr_en (pix_wr_en), .din (pix_word), .rd_en (video_valid & video_ready),
        .dout (pix_head), .full (pix_full), .empty (pix_empty), .count ()
    );

endmodule

`default_nettype wire

// ==== dv/ddr_read_model.sv ====
// ==============================
// DDR read responder model
// random latency, in order, address data
// ==============================
`timescale 1ns/1ps
`default_nettype none

module ddr_read_model
    import mem_pkg::*;
(
    input  wire logic      cpu_clk_g,
    input  wire logic      rst,
    input  wire logic      req_valid,
    output logic           req_ready,
    input  wire mem_addr_t req_addr,
    output logic           rd_valid,
    output mem_line_t      rd_data
);

    mem_addr_t addr_q[$];
    int        due_q[$];
    int        cycle;
    int        last_due;

    // word k carries its own byte address in the low 24 bits
    function automatic mem_line_t line_for(mem_addr_t addr);
        mem_line_t l;
        mem_addr_t a;
        l = '0;
        for (int k = 0; k < 4; k++) begin
            a = addr + mem_addr_t'(4 * k);
            l[32*k +: 32] = {8'h00, a[23:0]};
        end
        return l;
    endfunction

    always @(posedge cpu_clk_g) begin
        int due;
        mem_addr_t a;
        if (rst) begin
            req_ready <= 1'b0;
            rd_valid  <= 1'b0;
            rd_data   <= '0;
            cycle     = 0;
            last_due  = 0;
            addr_q.delete();
            due_q.delete();
        end else begin
            cycle = cycle + 1;
            if (req_valid && req_ready) begin
                // 2 to 9 cycles, never ahead of an older request
                due = cycle + 2 + int'($urandom % 8);
                if (due <= last_due)
                    due = last_due + 1;
                last_due = due;
                addr_q.push_back(req_addr);
                due_q.push_back(due);
            end
            // back-pressure on about a quarter of cycles
            req_ready <= ($urandom % 4) != 0;
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                a = addr_q.pop_front();
                void'(due_q.pop_front());
                rd_valid <= 1'b1;
                rd_data  <= line_for(a);
            end else begin
                rd_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/pixel_feeder_tb.sv ====
// ==============================
// pixel feeder testbench
// register table, pixel and irq checks
// ==============================
`timescale 1ns/1ps
`default_nettype none
`include "pixel_feeder_cfg.svh"

module pixel_feeder_tb
    import mem_pkg::*;
    import video_pkg::*;
;

    localparam int FRAME_PIX   = `FRAME_WIDTH * `FRAME_HEIGHT;
    localparam int FRAME_LINES = FRAME_PIX / `LINE_PIXELS;
    localparam int FRAMES      = 3;
    localparam int LIMIT       = FRAMES * `FRAME_WIDTH * `FRAME_HEIGHT * 40 + 2000;
    localparam int OP_WR = 0, OP_RD = 1, OP_WAITPIX = 2, OP_DRAIN = 3;

    typedef struct {
        int          op;
        reg_addr_t   addr;
        logic [31:0] data;
        logic [31:0] exp;
        bit          use_model;
    } axi_op_t;

    logic cpu_clk_g = 1'b0;
    logic rst;
    reg_addr_t awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        req_valid, req_ready, rd_valid, video_valid, video_ready, irq;
    mem_addr_t   req_addr;
    mem_line_t   rd_data;
    pixel_t      video;

    axi_op_t     ops[$];
    mem_addr_t   base_exp[8];
    int          errors = 0;
    int          cycles = 0;
    int          pix_count = 0;
    int          nreq = 0;
    bit          en_seen = 0;
    logic        done_m = 0;
    logic        irq_en_m = 0;
    logic [15:0] fcount_m = 0;
    logic [31:0] model_rd;

    always #4 cpu_clk_g = ~cpu_clk_g;

    pixel_feeder pixel_feeder_i (.*);

    ddr_read_model ddr_i (
        .cpu_clk_g (cpu_clk_g), .rst (rst), .req_valid (req_valid),
        .req_ready (req_ready), .req_addr (req_addr),
        .rd_valid (rd_valid), .rd_data (rd_data)
    );

    // watchdog
    always @(posedge cpu_clk_g) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish in %0d cycles, errors %0d", LIMIT, errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // random video back-pressure
    always @(posedge cpu_clk_g)
        video_ready <= ($urandom % 3) != 0;

    // reference model of status, irq, frame count and base schedule
    always @(posedge cpu_clk_g) begin
        bit fire;
        bit wr_acc;
        int n;
        int f;
        mem_addr_t a;
        fire   = req_valid && req_ready;
        wr_acc = awvalid && wvalid && awready;
        if (!rst) begin
            if (irq !== (done_m & irq_en_m)) begin
                $display("FAIL irq: got %h expected %h", irq, done_m & irq_en_m);
                errors++;
            end
            if (arvalid && arready)
                model_rd = (araddr == REG_STATUS) ? {31'b0, done_m} : {16'b0, fcount_m};
            // pixels must follow raster order from the frame base
            if (video_valid && video_ready) begin
                f = pix_count / FRAME_PIX;
                if (f > 7)
                    f = 7;
                a = base_exp[f] + mem_addr_t'((pix_count % FRAME_PIX) * 4);
                if (video !== a[23:0]) begin
                    $display("FAIL video: pixel %0d got %h expected %h", pix_count, video, a[23:0]);
                    errors++;
                end
                pix_count++;
            end
            // a base written now takes effect after the next frame wrap
            if (wr_acc && awaddr == REG_BASE) begin
                n = nreq + int'(fire);
                for (int i = en_seen ? n / FRAME_LINES + 1 : 0; i < 8; i++)
                    base_exp[i] = wdata[30:0];
            end
            if (wr_acc && awaddr == REG_CTRL) begin
                irq_en_m = wdata[1];
                if (wdata[0])
                    en_seen = 1;
            end
            if (fire && (nreq + 1) % FRAME_LINES == 0) begin
                done_m = 1'b1;
                fcount_m++;
            end else if (wr_acc && awaddr == REG_STATUS && wdata[0]) begin
                done_m = 1'b0;
            end
            if (fire)
                nreq++;
        end
    end

    task automatic add_op(int op, reg_addr_t addr, logic [31:0] data, logic [31:0] exp,
                          bit use_model);
        axi_op_t o;
        o.op = op;
        o.addr = addr;
        o.data = data;
        o.exp = exp;
        o.use_model = use_model;
        ops.push_back(o);
    endtask

    task automatic axi_write(reg_addr_t addr, logic [31:0] data);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hF;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge cpu_clk_g); while (!awready);
        // address and data channels are taken on the same edge
        if (wready !== 1'b1) begin
            $display("FAIL wready: got %h expected %h", wready, 1'b1);
            errors++;
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge cpu_clk_g); while (!bvalid);
        if (bresp !== 2'b00) begin
            $display("FAIL bresp: got %h expected %h", bresp, 2'b00);
            errors++;
        end
    endtask

    task automatic axi_read_check(reg_addr_t addr, logic [31:0] exp, bit use_model);
        logic [31:0] e;
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge cpu_clk_g); while (!arready);
        arvalid <= 1'b0;
        do @(posedge cpu_clk_g); while (!rvalid);
        e = use_model ? model_rd : exp;
        if (rdata !== e) begin
            $display("FAIL rdata: addr %h got %h expected %h", addr, rdata, e);
            errors++;
        end
        if (rresp !== 2'b00) begin
            $display("FAIL rresp: addr %h got %h expected %h", addr, rresp, 2'b00);
            errors++;
        end
    endtask

    // wait for the disabled feeder to go idle, then it must stay quiet
    task automatic drain_check();
        int idle_run;
        idle_run = 0;
        while (idle_run < 50) begin
            @(posedge cpu_clk_g);
            idle_run = (!req_valid && !video_valid) ? idle_run + 1 : 0;
        end
        repeat (50) begin
            @(posedge cpu_clk_g);
            if (req_valid || video_valid) begin
                $display("request or pixel appeared after the feeder was disabled and drained");
                errors++;
            end
        end
        if (pix_count != nreq * `LINE_PIXELS) begin
            $display("FAIL pix_count: got %h expected %h", pix_count, nreq * `LINE_PIXELS);
            errors++;
        end
    endtask

    initial begin
        void'($urandom(32'h8e12_7e64));
        rst <= 1'b1;
        awaddr <= '0;
        awvalid <= 1'b0;
        wdata <= '0;
        wstrb <= '0;
        wvalid <= 1'b0;
        bready <= 1'b1;
        araddr <= '0;
        arvalid <= 1'b0;
        rready <= 1'b1;
        video_ready <= 1'b0;
        for (int i = 0; i < 8; i++)
            base_exp[i] = '0;
        // reset values, then base and control readback
        add_op(OP_RD, REG_BASE, 0, 32'h0, 0);
        add_op(OP_RD, REG_CTRL, 0, 32'h0, 0);
        add_op(OP_RD, REG_STATUS, 0, 0, 1);
        add_op(OP_RD, REG_FCOUNT, 0, 0, 1);
        add_op(OP_WR, REG_BASE, 32'h0010_0000, 0, 0);
        add_op(OP_RD, REG_BASE, 0, 32'h0010_0000, 0);
        add_op(OP_WR, REG_CTRL, 32'h3, 0, 0);
        add_op(OP_RD, REG_CTRL, 0, 32'h3, 0);
        // new base in the middle of a frame
        add_op(OP_WAITPIX, 0, 64, 0, 0);
        add_op(OP_WR, REG_BASE, 32'h0020_0400, 0, 0);
        add_op(OP_RD, REG_BASE, 0, 32'h0020_0400, 0);
        add_op(OP_WAITPIX, 0, FRAME_PIX, 0, 0);
        add_op(OP_RD, REG_STATUS, 0, 0, 1);
        add_op(OP_RD, REG_FCOUNT, 0, 0, 1);
        add_op(OP_WR, REG_STATUS, 32'h1, 0, 0);
        add_op(OP_RD, REG_STATUS, 0, 0, 1);
        add_op(OP_WAITPIX, 0, 2 * FRAME_PIX + 40, 0, 0);
        add_op(OP_WR, REG_CTRL, 32'h2, 0, 0);
        add_op(OP_DRAIN, 0, 0, 0, 0);
        add_op(OP_RD, REG_FCOUNT, 0, 0, 1);
        add_op(OP_RD, REG_STATUS, 0, 0, 1);
        repeat (10) @(posedge cpu_clk_g);
        rst <= 1'b0;
        @(posedge cpu_clk_g);
        foreach (ops[i]) begin
            case (ops[i].op)
                OP_WR:      axi_write(ops[i].addr, ops[i].data);
                OP_RD:      axi_read_check(ops[i].addr, ops[i].exp, ops[i].use_model);
                OP_WAITPIX: while (pix_count < int'(ops[i].data)) @(posedge cpu_clk_g);
                OP_DRAIN:   drain_check();
            endcase
        end
        $display("errors: %0d, pixels checked: %0d", errors, pix_count);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
logic/mem_pkg.sv
logic/video_pkg.sv
logic/sync_fifo.sv
logic/feeder_regs.sv
logic/line_request_gen.sv
logic/line_unpacker.sv
logic/pixel_feeder.sv
dv/ddr_read_model.sv
dv/pixel_feeder_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pixel feeder simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module pixel_feeder_tb -o pixel_feeder_sim > build.log 2>&1 \
    && ./obj_dir/pixel_feeder_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "TESTBENCH FAILED" sim.log \
    && { echo "simulation failed, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
